// File: bt_bitproc.f
src/bt_bitproc_pkg.sv
src/pktype_decode.sv
src/hdr_encode.sv
src/whitening.sv
src/tx_buffer.sv
src/arq_ctrl.sv
src/tx_bit_ctrl.sv
src/bt_bitproc.sv
sim/tb_bt_bitproc.sv

// File: sim/tb_bt_bitproc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bt_bitproc
  import bt_bitproc_pkg::*;
();

  localparam int MAX_BITS       = HDR_BITS + MAX_PYBYTES * 8;
  localparam int TIMEOUT_CYCLES = 8 * MAX_BITS * 6 + 2000;

  logic clk_6M = 1'b0;
  logic rstz, p_1us, tx_packet_st_p;
  pk_type_e regi_packet_type;
  logic [LT_ADDR_W-1:0] regi_lt_addr;
  logic [UAP_W-1:0] regi_uap;
  logic regi_flow, regi_txwhitening;
  logic [PYLEN_W-1:0] regi_payloadlen;
  logic [27:0] bt_clk;
  logic [BUF_AW-1:0] txbsm_addr;
  logic [BUF_DW-1:0] txbsm_din;
  logic txbsm_we, dec_py_endp, dec_hecgood, dec_crcgood, dec_arqn;
  logic txbit, txbit_period, txbit_period_endp, extendslot, tx_arqn, tx_seqn;
  logic [PYBIT_W-1:0] pylenbit;

  logic [31:0] rnd = 32'ha816_1b2d;
  logic [BUF_DW-1:0] buf_mirror [0:BUF_WORDS-1];
  logic exp_bits [0:MAX_BITS-1];
  int exp_len, exp_idx, endp_seen, endp_cycle;
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int div_cnt = 0;
  string test_name = "reset";
  logic model_arqn, model_seqn, model_ack;
  pk_type_e type_list [0:7];

  bt_bitproc uut (.*);

  always #10 clk_6M = ~clk_6M;

  always @(posedge clk_6M)
  begin
    div_cnt <= (div_cnt == 5) ? 0 : div_cnt + 1;
    p_1us   <= (div_cnt == 5);
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic carries_payload(input pk_type_e t);
    return (t == DM1 || t == DH1 || t == DM3 || t == DH3 || t == DM5 || t == DH5);
  endfunction

  function automatic logic [PYBIT_W-1:0] pylen_ref(input pk_type_e t, input int len);
    return carries_payload(t) ? PYBIT_W'(len * 8) : '0;
  endfunction

  function automatic int slots_ref(input pk_type_e t);
    case (t)
      DM3, DH3: return 3;
      DM5, DH5: return 5;
      default:  return 1;
    endcase
  endfunction

  // taps 0,1,2,5,7
  function automatic logic [7:0] hec_ref(input logic [9:0] f, input logic [7:0] uap);
    logic [7:0] r;
    logic fb;
    begin
      r = uap;
      for (int i = 0; i < 10; i++)
      begin
        fb = f[i] ^ r[7];
        r  = {r[6:0], 1'b0};
        if (fb)
          r = r ^ 8'b1010_0111;
      end
      return r;
    end
  endfunction

  function automatic logic [6:0] white_next(input logic [6:0] w);
    logic [6:0] n;
    begin
      n    = w << 1;
      n[0] = w[6];         // old msb wraps around
      n[4] = n[4] ^ w[6];
      return n;
    end
  endfunction

  task automatic build_expected(input pk_type_e t, input int len, input logic [2:0] lt,
                                input logic flow, input logic [7:0] uap,
                                input logic [27:0] clk_v, input logic wh);
    logic [9:0] f;
    logic [7:0] h;
    logic [6:0] w;
    int n;
    begin
      f = {model_seqn, model_arqn, flow, t, lt};
      h = hec_ref(f, uap);
      n = pylen_ref(t, len);
      for (int i = 0; i < 10; i++)
        exp_bits[i] = f[i];
      for (int i = 0; i < 8; i++)
        exp_bits[10+i] = h[7-i];
      for (int i = 0; i < n; i++)
        exp_bits[HDR_BITS+i] = buf_mirror[i/32][i%32];  // bytes lsb first
      exp_len = HDR_BITS + n;
      w = {1'b1, clk_v[6:1]};
      for (int i = 0; i < exp_len; i++)
      begin
        if (wh)
          exp_bits[i] = exp_bits[i] ^ w[6];
        w = white_next(w);
      end
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input logic [PYBIT_W-1:0] exp,
                           input logic [PYBIT_W-1:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_type_slots(input pk_type_e t, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL extendslot type %0d: expected %b, actual %b", t, exp, act);
    end
  endtask

  task automatic complain(input string msg);
    errors++;
    $display("%s in %s", msg, test_name);
  endtask

  // bit compare on every p_1us of the packet
  always @(negedge clk_6M)
  begin
    if (rstz && txbit_period && p_1us)
    begin
      if (exp_idx < exp_len)
        check_bit($sformatf("%s bit %0d", test_name, exp_idx), exp_bits[exp_idx], txbit);
      else
        complain("txbit_period still high after the last bit");
      if (txbit_period_endp)
      begin
        endp_seen++;
        endp_cycle = cycles;
        if (exp_idx != exp_len - 1)
          complain($sformatf("txbit_period_endp on bit %0d of %0d", exp_idx, exp_len));
      end
      exp_idx++;
    end
    else if (rstz && txbit_period_endp)
      complain("txbit_period_endp without a bit being consumed");
  end

  always @(posedge clk_6M)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a packet never finished", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic fill_buffer;
    for (int a = 0; a < BUF_WORDS; a++)
    begin
      rnd = lcg_step(rnd);
      buf_mirror[a] = rnd;
      @(posedge clk_6M);
      txbsm_addr <= a[BUF_AW-1:0];
      txbsm_din  <= rnd;
      txbsm_we   <= 1'b1;
    end
    @(posedge clk_6M);
    txbsm_we <= 1'b0;
  endtask

  task automatic send_packet(input string name, input pk_type_e t, input int len,
                             input logic wh);
    logic [7:0] uap;
    logic [27:0] clk_v;
    logic [2:0] lt;
    logic flow;
    begin
      rnd = lcg_step(rnd);
      uap = rnd[23:16];
      lt = rnd[30:28];
      flow = rnd[31];
      rnd = lcg_step(rnd);
      clk_v = rnd[27:0];
      if (carries_payload(t) && model_ack)
        model_seqn = ~model_seqn;
      if (carries_payload(t))
        model_ack = 1'b0;
      build_expected(t, len, lt, flow, uap, clk_v, wh);
      test_name = name;
      exp_idx = 0;
      endp_seen = 0;
      @(posedge clk_6M);
      regi_packet_type <= t;
      regi_payloadlen  <= len;
      regi_lt_addr     <= lt;
      regi_uap         <= uap;
      regi_flow        <= flow;
      regi_txwhitening <= wh;
      bt_clk           <= clk_v;
      tx_packet_st_p   <= 1'b1;
      @(posedge clk_6M);
      tx_packet_st_p <= 1'b0;
      @(negedge clk_6M);
      if (!txbit_period)
        complain("txbit_period did not rise after tx_packet_st_p");
      while (txbit_period)
        @(negedge clk_6M);
      if (endp_seen != 1)
        complain($sformatf("saw %0d txbit_period_endp pulses instead of one", endp_seen));
      else if (cycles != endp_cycle + 1)
        complain("txbit_period did not fall the cycle after txbit_period_endp");
      if (exp_idx != exp_len)
        complain($sformatf("packet sent %0d bits, expected %0d", exp_idx, exp_len));
      check_bit({name, " idle txbit"}, 1'b0, txbit);
    end
  endtask

  task automatic receive_result(input logic hec, input logic crc, input logic ack);
    @(posedge clk_6M);
    dec_py_endp <= 1'b1;
    dec_hecgood <= hec;
    dec_crcgood <= crc;
    dec_arqn    <= ack;
    @(posedge clk_6M);
    dec_py_endp <= 1'b0;
    model_arqn = hec & crc;
    if (hec & ack)
      model_ack = 1'b1;
    @(negedge clk_6M);
    check_flag("tx_arqn after rx result", model_arqn, tx_arqn);
  endtask

  initial
  begin
    rstz = 1'b0;
    p_1us = 1'b0;
    tx_packet_st_p = 1'b0;
    regi_packet_type = NULL;
    regi_lt_addr = '0;
    regi_uap = '0;
    regi_flow = 1'b0;
    regi_payloadlen = '0;
    regi_txwhitening = 1'b0;
    bt_clk = '0;
    txbsm_addr = '0;
    txbsm_din = '0;
    txbsm_we = 1'b0;
    dec_py_endp = 1'b0;
    dec_hecgood = 1'b0;
    dec_crcgood = 1'b0;
    dec_arqn = 1'b0;
    model_arqn = 1'b0;
    model_seqn = 1'b1;
    model_ack = 1'b0;
    type_list = '{NULL, POLL, DM1, DH1, DM3, DH3, DM5, DH5};
    repeat (5) @(posedge clk_6M);
    rstz <= 1'b1;
    @(negedge clk_6M);
    check_flag("reset txbit_period", 1'b0, txbit_period);
    check_flag("reset txbit_period_endp", 1'b0, txbit_period_endp);
    check_flag("reset txbit", 1'b0, txbit);
    check_flag("reset tx_arqn", 1'b0, tx_arqn);
    check_flag("reset tx_seqn", 1'b1, tx_seqn);

    // type table over every type and length
    for (int ti = 0; ti < 8; ti++)
    begin
      for (int len = 0; len <= MAX_PYBYTES; len++)
      begin
        @(posedge clk_6M);
        regi_packet_type <= type_list[ti];
        regi_payloadlen  <= len;
        @(negedge clk_6M);
        check_len($sformatf("pylenbit type %0d len %0d", type_list[ti], len),
                  pylen_ref(type_list[ti], len), pylenbit);
        check_type_slots(type_list[ti], slots_ref(type_list[ti]) > 1, extendslot);
      end
    end

    send_packet("null header", NULL, 5, 1'b0);
    fill_buffer;
    rnd = lcg_step(rnd);
    send_packet("dh1 whitened", DH1, 1 + rnd % 32, 1'b1);
    fill_buffer;
    rnd = lcg_step(rnd);
    send_packet("dm3 whitened", DM3, 1 + rnd % 32, 1'b1);
    fill_buffer;
    rnd = lcg_step(rnd);
    send_packet("dh5 whitened", DH5, 1 + rnd % 32, 1'b1);

    receive_result(1'b1, 1'b1, 1'b0);
    send_packet("dm1 arqn good", DM1, 4, 1'b0);
    check_flag("seqn without ack", model_seqn, tx_seqn);
    receive_result(1'b1, 1'b0, 1'b1);
    send_packet("poll arqn bad", POLL, 0, 1'b1);
    check_flag("seqn after poll", model_seqn, tx_seqn);
    send_packet("dm1 seqn toggle", DM1, 8, 1'b1);
    check_flag("seqn after acked dm1", model_seqn, tx_seqn);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/arq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module arq_ctrl
  import bt_bitproc_pkg::*;
(
  input  logic     clk_6M,
  input  logic     rstz,
  input  logic     load,
  input  pk_type_e pk_type,
  input  logic     dec_py_endp,
  input  logic     dec_hecgood,
  input  logic     dec_crcgood,
  input  logic     dec_arqn,
  output logic     tx_arqn,
  output logic     tx_seqn
);

  logic seqn_q;
  logic ack_pend;  // last data packet acked by peer
  logic seqn_flip;

  assign seqn_flip = load & is_data_type(pk_type) & ack_pend;

  // header latches on load, so it must see the new seqn that same cycle
  assign tx_seqn = seqn_q ^ seqn_flip;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_arqn  <= 1'b0;
      seqn_q   <= 1'b1;
      ack_pend <= 1'b0;
    end
    else
    begin
      if (dec_py_endp)
        tx_arqn <= dec_hecgood & dec_crcgood;
      if (seqn_flip)
        seqn_q <= ~seqn_q;
      if (dec_py_endp & dec_hecgood & dec_arqn)
        ack_pend <= 1'b1;
      else if (load & is_data_type(pk_type))
        ack_pend <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/bt_bitproc.sv
`timescale 1ns/1ps
`default_nettype none

module bt_bitproc
  import bt_bitproc_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 p_1us,
  input  logic                 tx_packet_st_p,
  input  pk_type_e             regi_packet_type,
  input  logic [LT_ADDR_W-1:0] regi_lt_addr,
  input  logic [UAP_W-1:0]     regi_uap,
  input  logic                 regi_flow,
  input  logic [PYLEN_W-1:0]   regi_payloadlen,
  input  logic                 regi_txwhitening,
  input  logic [27:0]          bt_clk,
  input  logic [BUF_AW-1:0]    txbsm_addr,
  input  logic [BUF_DW-1:0]    txbsm_din,
  input  logic                 txbsm_we,
  input  logic                 dec_py_endp,
  input  logic                 dec_hecgood,
  input  logic                 dec_crcgood,
  input  logic                 dec_arqn,
  output logic                 txbit,
  output logic                 txbit_period,
  output logic                 txbit_period_endp,
  output logic [PYBIT_W-1:0]   pylenbit,
  output logic                 extendslot,
  output logic                 tx_arqn,
  output logic                 tx_seqn
);

  logic               load, adv, hdr_shift, busy;
  logic [PYBIT_W-1:0] py_idx;
  logic               hdr_bit, py_bit, white_bit;

  pktype_decode pktype_decode_u (
    .pk_type    (regi_packet_type),
    .payloadlen (regi_payloadlen ),
    .pylenbit   (pylenbit        ),
    .extendslot (extendslot      )
  );

  hdr_encode hdr_encode_u (
    .clk_6M  (clk_6M          ),
    .rstz    (rstz            ),
    .load    (load            ),
    .shift   (hdr_shift       ),
    .lt_addr (regi_lt_addr    ),
    .pk_type (regi_packet_type),
    .flow    (regi_flow       ),
    .arqn    (tx_arqn         ),
    .seqn    (tx_seqn         ),
    .uap     (regi_uap        ),
    .hdr_bit (hdr_bit         )
  );

  whitening whitening_u (
    .clk_6M    (clk_6M   ),
    .rstz      (rstz     ),
    .load      (load     ),
    .step      (adv      ),
    .bt_clk    (bt_clk   ),
    .white_bit (white_bit)
  );

  tx_buffer tx_buffer_u (
    .clk_6M     (clk_6M    ),
    .txbsm_addr (txbsm_addr),
    .txbsm_din  (txbsm_din ),
    .txbsm_we   (txbsm_we  ),
    .busy       (busy      ),
    .py_idx     (py_idx    ),
    .py_bit     (py_bit    )
  );

  arq_ctrl arq_ctrl_u (
    .clk_6M      (clk_6M          ),
    .rstz        (rstz            ),
    .load        (load            ),
    .pk_type     (regi_packet_type),
    .dec_py_endp (dec_py_endp     ),
    .dec_hecgood (dec_hecgood     ),
    .dec_crcgood (dec_crcgood     ),
    .dec_arqn    (dec_arqn        ),
    .tx_arqn     (tx_arqn         ),
    .tx_seqn     (tx_seqn         )
  );

  tx_bit_ctrl tx_bit_ctrl_u (
    .clk_6M            (clk_6M           ),
    .rstz              (rstz             ),
    .p_1us             (p_1us            ),
    .tx_packet_st_p    (tx_packet_st_p   ),
    .pylenbit          (pylenbit         ),
    .hdr_bit           (hdr_bit          ),
    .py_bit            (py_bit           ),
    .white_bit         (white_bit        ),
    .whiten_en         (regi_txwhitening ),
    .load              (load             ),
    .adv               (adv              ),
    .hdr_shift         (hdr_shift        ),
    .py_idx            (py_idx           ),
    .busy              (busy             ),
    .txbit             (txbit            ),
    .txbit_period      (txbit_period     ),
    .txbit_period_endp (txbit_period_endp)
  );

endmodule

`default_nettype wire

// File: src/bt_bitproc_pkg.sv
`default_nettype none

package bt_bitproc_pkg;

  // BR packet types on the header TYPE field
  typedef enum logic [3:0] {
    NULL = 4'd0,
    POLL = 4'd1,
    DM1  = 4'd3,
    DH1  = 4'd4,
    DM3  = 4'd10,
    DH3  = 4'd11,
    DM5  = 4'd14,
    DH5  = 4'd15
  } pk_type_e;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    PAYLOAD
  } tx_phase_e;

  localparam int LT_ADDR_W   = 3;
  localparam int UAP_W       = 8;
  localparam int HDR_BITS    = 18;  // 10 field bits + 8 hec bits
  localparam int PYLEN_W     = 10;
  localparam int PYBIT_W     = 13;
  localparam int BUF_WORDS   = 8;
  localparam int BUF_AW      = 3;
  localparam int BUF_DW      = 32;
  localparam int MAX_PYBYTES = 32;
  localparam int WHITE_W     = 7;

  // D^8 + D^7 + D^5 + D^2 + D + 1
  localparam logic [UAP_W-1:0] HEC_POLY = 8'b1010_0111;

  // DM/DH types carry a buffer payload
  function automatic logic is_data_type(input pk_type_e t);
    case (t)
      DM1, DH1, DM3, DH3, DM5, DH5: is_data_type = 1'b1;
      default:                      is_data_type = 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: src/hdr_encode.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_encode
  import bt_bitproc_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 load,
  input  logic                 shift,
  input  logic [LT_ADDR_W-1:0] lt_addr,
  input  pk_type_e             pk_type,
  input  logic                 flow,
  input  logic                 arqn,
  input  logic                 seqn,
  input  logic [UAP_W-1:0]     uap,
  output logic                 hdr_bit
);

  logic [HDR_BITS-UAP_W-1:0] fields;
  logic [UAP_W-1:0]          hec;
  logic                      fb;
  logic [HDR_BITS-1:0]       hdr_load;
  logic [HDR_BITS-1:0]       hdr_sr;

  always_comb
  begin
    fields = {seqn, arqn, flow, pk_type, lt_addr};  // bit 0 goes out first
    hec = uap;
    fb = 1'b0;
    for (int i = 0; i < HDR_BITS - UAP_W; i++)
    begin
      fb  = fields[i] ^ hec[UAP_W-1];
      hec = {hec[UAP_W-2:0], 1'b0} ^ (fb ? HEC_POLY : '0);
    end

    hdr_load[HDR_BITS-UAP_W-1:0] = fields;
    // hec msb first after the fields
    for (int k = 0; k < UAP_W; k++)
    begin
      hdr_load[HDR_BITS-UAP_W+k] = hec[UAP_W-1-k];
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hdr_sr <= '0;
    else if (load)
      hdr_sr <= hdr_load;
    else if (shift)
      hdr_sr <= {1'b0, hdr_sr[HDR_BITS-1:1]};
  end

  assign hdr_bit = hdr_sr[0];

endmodule

`default_nettype wire

// File: src/pktype_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pktype_decode
  import bt_bitproc_pkg::*;
(
  input  pk_type_e             pk_type,
  input  logic [PYLEN_W-1:0]   payloadlen,
  output logic [PYBIT_W-1:0]   pylenbit,
  output logic                 extendslot
);

  logic [2:0] slots;

  always_comb
  begin
    case (pk_type)
      NULL, POLL, DM1, DH1: slots = 3'd1;
      DM3, DH3:             slots = 3'd3;
      DM5, DH5:             slots = 3'd5;
      default:              slots = 3'd1;  // undefined codes stay single slot
    endcase
  end

  // bytes to bits, control packets carry nothing
  assign pylenbit = is_data_type(pk_type) ? {payloadlen, 3'b000} : '0;

  assign extendslot = (slots > 3'd1);

  // the transmit buffer only holds MAX_PYBYTES
  a_pylen_range: assert #0 (!is_data_type(pk_type) || payloadlen <= MAX_PYBYTES)
    else $error("payloadlen %0d exceeds buffer size", payloadlen);

endmodule

`default_nettype wire

// File: src/tx_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tx_bit_ctrl
  import bt_bitproc_pkg::*;
(
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               p_1us,
  input  logic               tx_packet_st_p,
  input  logic [PYBIT_W-1:0] pylenbit,
  input  logic               hdr_bit,
  input  logic               py_bit,
  input  logic               white_bit,
  input  logic               whiten_en,
  output logic               load,
  output logic               adv,
  output logic               hdr_shift,
  output logic [PYBIT_W-1:0] py_idx,
  output logic               busy,
  output logic               txbit,
  output logic               txbit_period,
  output logic               txbit_period_endp
);

  tx_phase_e                     phase;
  logic [$clog2(HDR_BITS)-1:0]   hdr_cnt;
  logic                          hdr_last;
  logic                          py_last;
  logic                          raw_bit;

  assign load      = tx_packet_st_p & (phase == IDLE);
  assign adv       = p_1us & (phase != IDLE);
  assign hdr_shift = adv & (phase == HEADER);

  assign hdr_last = (hdr_cnt == HDR_BITS - 1);
  assign py_last  = (py_idx == pylenbit - 1'b1);

  // last bit consumed, header only when there is no payload
  assign txbit_period_endp = adv & (((phase == HEADER) & hdr_last & (pylenbit == '0)) |
                                    ((phase == PAYLOAD) & py_last));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      phase   <= IDLE;
      hdr_cnt <= '0;
      py_idx  <= '0;
    end
    else
    begin
      case (phase)
        IDLE:
          if (load)
          begin
            phase   <= HEADER;
            hdr_cnt <= '0;
            py_idx  <= '0;
          end
        HEADER:
          if (adv)
          begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last)
              phase <= (pylenbit != '0) ? PAYLOAD : IDLE;
          end
        PAYLOAD:
          if (adv)
          begin
            py_idx <= py_idx + 1'b1;
            if (py_last)
              phase <= IDLE;
          end
        default: phase <= IDLE;
      endcase
    end
  end

  always_comb
  begin
    case (phase)
      HEADER:  raw_bit = hdr_bit;
      PAYLOAD: raw_bit = py_bit;
      default: raw_bit = 1'b0;
    endcase
  end

  assign txbit        = raw_bit ^ (whiten_en & (phase != IDLE) & white_bit);
  assign txbit_period = (phase != IDLE);
  assign busy         = txbit_period;  // buffer locked for the whole packet

  a_start_idle: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_packet_st_p |-> phase == IDLE)
    else $error("tx_packet_st_p while a packet is in flight");

  a_endp_pulse: assert property (@(posedge clk_6M) disable iff (!rstz)
    txbit_period_endp |=> !txbit_period_endp && !txbit_period)
    else $error("txbit_period_endp not a single pulse");

endmodule

`default_nettype wire

// File: src/tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_buffer
  import bt_bitproc_pkg::*;
(
  input  logic               clk_6M,
  input  logic [BUF_AW-1:0]  txbsm_addr,
  input  logic [BUF_DW-1:0]  txbsm_din,
  input  logic               txbsm_we,
  input  logic               busy,
  input  logic [PYBIT_W-1:0] py_idx,
  output logic               py_bit
);

  logic [BUF_DW-1:0] mem [BUF_WORDS];
  logic [BUF_DW-1:0] rd_word;

  // host side
  always_ff @(posedge clk_6M)
  begin
    if (txbsm_we)
      mem[txbsm_addr] <= txbsm_din;
  end

  // word = idx / 32, bit = idx mod 32, so bytes leave lsb first
  assign rd_word = mem[py_idx[$clog2(BUF_DW) +: BUF_AW]];
  assign py_bit  = rd_word[py_idx[$clog2(BUF_DW)-1:0]];

  // payload must not change under the bit reader
  a_no_wr_busy: assert property (@(posedge clk_6M) txbsm_we |-> !busy)
    else $error("host write to tx buffer during packet");

endmodule

`default_nettype wire

// File: src/whitening.sv
`timescale 1ns/1ps
`default_nettype none

module whitening
  import bt_bitproc_pkg::*;
(
  input  logic        clk_6M,
  input  logic        rstz,
  input  logic        load,
  input  logic        step,
  input  logic [27:0] bt_clk,
  output logic        white_bit
);

  logic [WHITE_W-1:0] lfsr;

  // g(D) = D^7 + D^4 + 1
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lfsr <= '0;
    else if (load)
      lfsr <= {1'b1, bt_clk[6:1]};  // seed from CLK6-1
    else if (step)
      lfsr <= {lfsr[WHITE_W-2:0], lfsr[WHITE_W-1]} ^ {2'b00, lfsr[WHITE_W-1], 4'b0000};
  end

  assign white_bit = lfsr[WHITE_W-1];

endmodule

`default_nettype wire
